//--- source/exec_config.svh
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Entries held by each reservation station
`define EXEC_RS_DEPTH 8

// Producer tag width, one tag per instruction in flight
`define EXEC_TAG_W 6

// Integer datapath width
`define EXEC_DATA_W 32

// Multiplier latency from issue to result
`define EXEC_MUL_STAGES 3

`endif

//--- source/exec_types_pkg.sv
`default_nettype none

`include "exec_config.svh"

package exec_types_pkg;

    // Target station
    typedef enum logic {
        UNIT_ALU = 1'b0,
        UNIT_MUL = 1'b1
    } unit_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_SLL, ALU_SRL, ALU_SLT
    } alu_op_e;

    // mulh is signed x signed, mulhu is unsigned x unsigned
    typedef enum logic [1:0] {
        MUL_MUL, MUL_MULH, MUL_MULHU
    } mul_op_e;

    // Tag view of an operand word, upper bits zero
    typedef struct packed {
        logic [`EXEC_DATA_W-`EXEC_TAG_W-1:0] pad;
        logic [`EXEC_TAG_W-1:0]              tag;
    } tag_word_t;

    // Same word read as a value once ready, else as the producer tag
    typedef union packed {
        logic [`EXEC_DATA_W-1:0] value;
        tag_word_t               src;
    } operand_u;

    typedef struct packed {
        logic     ready;
        operand_u word;
    } operand_t;

    typedef struct packed {
        unit_e                  unit;
        logic [2:0]             op;
        logic [`EXEC_TAG_W-1:0] dest;
        operand_t               src1;
        operand_t               src2;
    } dispatch_t;

endpackage

`default_nettype wire

//--- source/exec_bus_pkg.sv
`default_nettype none

`include "exec_config.svh"

package exec_bus_pkg;

    // Instruction sent to a functional unit with both operands resolved
    typedef struct packed {
        logic [2:0]              op;
        logic [`EXEC_TAG_W-1:0]  tag;
        logic [`EXEC_DATA_W-1:0] src1;
        logic [`EXEC_DATA_W-1:0] src2;
    } issue_t;

    // Result broadcast, also used for unit outputs before arbitration
    typedef struct packed {
        logic                    valid;
        logic [`EXEC_TAG_W-1:0]  tag;
        logic [`EXEC_DATA_W-1:0] value;
    } cdb_t;

endpackage

`default_nettype wire

//--- source/reservation_station.sv
`default_nettype none

`include "exec_config.svh"

module reservation_station #(
    parameter exec_types_pkg::unit_e UNIT = exec_types_pkg::UNIT_ALU
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      dispatch_valid,
    input  exec_types_pkg::dispatch_t dispatch,
    input  exec_bus_pkg::cdb_t        cdb,
    input  logic                      unit_ready,
    output logic                      issue_valid,
    output exec_bus_pkg::issue_t      issue,
    output logic                      full
);

    localparam int DEPTH = `EXEC_RS_DEPTH;
    localparam int AGE_W = $clog2(DEPTH);

    typedef struct packed {
        logic [2:0]               op;
        logic [`EXEC_TAG_W-1:0]   dest;
        exec_types_pkg::operand_t src1;
        exec_types_pkg::operand_t src2;
    } entry_t;

    entry_t           ent [DEPTH];
    logic [DEPTH-1:0] ent_valid;
    logic [DEPTH-1:0] ent_ready;
    // Age counts the valid entries younger than this one, so oldest has the largest
    logic [AGE_W-1:0] ent_age [DEPTH];
    logic [AGE_W-1:0] age_nxt [DEPTH];

    logic             accept;
    logic             fire;
    logic             issue_found;
    logic [AGE_W-1:0] issue_idx;
    logic [AGE_W-1:0] free_idx;

    // Capture a broadcast value into a waiting operand
    function automatic exec_types_pkg::operand_t wake(exec_types_pkg::operand_t opnd,
                                                      exec_bus_pkg::cdb_t bus);
        exec_types_pkg::operand_t res;
        res = opnd;
        if (!opnd.ready && bus.valid && opnd.word.src.tag == bus.tag) begin
            res.ready      = 1'b1;
            res.word.value = bus.value;
        end
        return res;
    endfunction

    assign full   = &ent_valid;
    assign accept = dispatch_valid && (dispatch.unit == UNIT) && !full;
    assign fire   = issue_found && unit_ready;

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            ent_ready[i] = ent_valid[i] && ent[i].src1.ready && ent[i].src2.ready;
        end
    end

    // Lowest free slot and oldest ready entry
    always_comb begin
        free_idx    = '0;
        issue_found = 1'b0;
        issue_idx   = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                free_idx = AGE_W'(i);
            end
        end
        for (int i = 0; i < DEPTH; i++) begin
            if (ent_ready[i] && (!issue_found || ent_age[i] > ent_age[issue_idx])) begin
                issue_found = 1'b1;
                issue_idx   = AGE_W'(i);
            end
        end
    end

    // New entry ages everyone, an issue makes older entries one younger
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            age_nxt[i] = ent_age[i];
            if (accept) begin
                age_nxt[i] = age_nxt[i] + AGE_W'(1);
            end
            if (fire && ent_age[i] > ent_age[issue_idx]) begin
                age_nxt[i] = age_nxt[i] - AGE_W'(1);
            end
        end
    end

    assign issue_valid = fire;
    assign issue = '{
        op:   ent[issue_idx].op,
        tag:  ent[issue_idx].dest,
        src1: ent[issue_idx].src1.word.value,
        src2: ent[issue_idx].src2.word.value
    };

    always_ff @(posedge clk) begin
        if (rst) begin
            ent_valid <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                ent_age[i] <= '0;
            end
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                ent_age[i] <= age_nxt[i];
            end
            if (fire) begin
                ent_valid[issue_idx] <= 1'b0;
            end
            if (accept) begin
                ent_valid[free_idx] <= 1'b1;
                ent_age[free_idx]   <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            ent[i].src1 <= wake(ent[i].src1, cdb);
            ent[i].src2 <= wake(ent[i].src2, cdb);
        end
        // Incoming operands also see this cycle's broadcast
        if (accept) begin
            ent[free_idx] <= '{
                op:   dispatch.op,
                dest: dispatch.dest,
                src1: wake(dispatch.src1, cdb),
                src2: wake(dispatch.src2, cdb)
            };
        end
    end

endmodule

`default_nettype wire

//--- source/alu_unit.sv
`default_nettype none

`include "exec_config.svh"

module alu_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue_valid,
    input  exec_bus_pkg::issue_t issue,
    input  logic                 grant,
    output logic                 unit_ready,
    output logic                 result_valid,
    output exec_bus_pkg::cdb_t   result
);

    logic [`EXEC_DATA_W-1:0] alu_out;
    logic [`EXEC_DATA_W-1:0] res_value;
    logic [`EXEC_TAG_W-1:0]  res_tag;

    always_comb begin
        case (exec_types_pkg::alu_op_e'(issue.op))
            exec_types_pkg::ALU_ADD: alu_out = issue.src1 + issue.src2;
            exec_types_pkg::ALU_SUB: alu_out = issue.src1 - issue.src2;
            exec_types_pkg::ALU_AND: alu_out = issue.src1 & issue.src2;
            exec_types_pkg::ALU_OR:  alu_out = issue.src1 | issue.src2;
            exec_types_pkg::ALU_XOR: alu_out = issue.src1 ^ issue.src2;
            exec_types_pkg::ALU_SLL: alu_out = issue.src1 << issue.src2[4:0];
            exec_types_pkg::ALU_SRL: alu_out = issue.src1 >> issue.src2[4:0];
            default: alu_out = `EXEC_DATA_W'($signed(issue.src1) < $signed(issue.src2));
        endcase
    end

    // Free when empty or when the held result leaves this cycle
    assign unit_ready = !result_valid || grant;

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else if (issue_valid && unit_ready) begin
            result_valid <= 1'b1;
        end else if (grant) begin
            result_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && unit_ready) begin
            res_value <= alu_out;
            res_tag   <= issue.tag;
        end
    end

    assign result = '{valid: result_valid, tag: res_tag, value: res_value};

endmodule

`default_nettype wire

//--- source/mul_unit.sv
`default_nettype none

`include "exec_config.svh"

module mul_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue_valid,
    input  exec_bus_pkg::issue_t issue,
    input  logic                 grant,
    output logic                 unit_ready,
    output logic                 result_valid,
    output exec_bus_pkg::cdb_t   result
);

    localparam int STAGES = `EXEC_MUL_STAGES;
    localparam int DW     = `EXEC_DATA_W;

    logic [STAGES-1:0]       stg_valid;
    logic [`EXEC_TAG_W-1:0]  stg_tag [STAGES];
    exec_types_pkg::mul_op_e stg_op  [STAGES];
    // Stage 0 holds extended operands, later stages the full product
    logic [DW:0]             s0_a;
    logic [DW:0]             s0_b;
    logic [2*DW-1:0]         stg_prod [1:STAGES-1];
    logic [2*DW+1:0]         product;
    logic                    advance;
    logic                    op_signed;

    // Whole pipe moves only when its tail can drain
    assign advance    = !stg_valid[STAGES-1] || grant;
    assign unit_ready = advance;

    // Only mulh treats both operands as signed
    assign op_signed = exec_types_pkg::mul_op_e'(issue.op[1:0]) == exec_types_pkg::MUL_MULH;
    assign product   = $signed({{(DW+1){s0_a[DW]}}, s0_a})
                     * $signed({{(DW+1){s0_b[DW]}}, s0_b});

    always_ff @(posedge clk) begin
        if (rst) begin
            stg_valid <= '0;
        end else if (advance) begin
            stg_valid <= {stg_valid[STAGES-2:0], issue_valid};
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            s0_a       <= {op_signed & issue.src1[DW-1], issue.src1};
            s0_b       <= {op_signed & issue.src2[DW-1], issue.src2};
            stg_tag[0] <= issue.tag;
            stg_op[0]  <= exec_types_pkg::mul_op_e'(issue.op[1:0]);
            stg_prod[1] <= product[2*DW-1:0];
            for (int i = 1; i < STAGES; i++) begin
                stg_tag[i] <= stg_tag[i-1];
                stg_op[i]  <= stg_op[i-1];
            end
            for (int i = 2; i < STAGES; i++) begin
                stg_prod[i] <= stg_prod[i-1];
            end
        end
    end

    assign result_valid = stg_valid[STAGES-1];
    assign result = '{
        valid: stg_valid[STAGES-1],
        tag:   stg_tag[STAGES-1],
        value: (stg_op[STAGES-1] == exec_types_pkg::MUL_MUL) ?
               stg_prod[STAGES-1][DW-1:0] : stg_prod[STAGES-1][2*DW-1:DW]
    };

endmodule

`default_nettype wire

//--- source/cdb_arbiter.sv
`default_nettype none

`include "exec_config.svh"

module cdb_arbiter (
    input  logic               clk,
    input  logic               rst,
    input  logic               alu_valid,
    input  exec_bus_pkg::cdb_t alu_result,
    input  logic               mul_valid,
    input  exec_bus_pkg::cdb_t mul_result,
    output logic               alu_grant,
    output logic               mul_grant,
    output exec_bus_pkg::cdb_t cdb
);

    logic                    cdb_valid;
    logic [`EXEC_TAG_W-1:0]  cdb_tag;
    logic [`EXEC_DATA_W-1:0] cdb_value;

    // Multiplier wins so its pipeline keeps moving
    assign mul_grant = mul_valid;
    assign alu_grant = alu_valid && !mul_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= mul_grant || alu_grant;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_grant) begin
            cdb_tag   <= mul_result.tag;
            cdb_value <= mul_result.value;
        end else if (alu_grant) begin
            cdb_tag   <= alu_result.tag;
            cdb_value <= alu_result.value;
        end
    end

    assign cdb = '{valid: cdb_valid, tag: cdb_tag, value: cdb_value};

endmodule

`default_nettype wire

//--- source/exec_core.sv
`default_nettype none

module exec_core (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      dispatch_valid,
    input  exec_types_pkg::dispatch_t dispatch,
    output logic                      alu_full,
    output logic                      mul_full,
    output exec_bus_pkg::cdb_t        cdb
);

    logic                 alu_issue_valid;
    logic                 mul_issue_valid;
    exec_bus_pkg::issue_t alu_issue;
    exec_bus_pkg::issue_t mul_issue;
    logic                 alu_unit_ready;
    logic                 mul_unit_ready;
    logic                 alu_res_valid;
    logic                 mul_res_valid;
    exec_bus_pkg::cdb_t   alu_res;
    exec_bus_pkg::cdb_t   mul_res;
    logic                 alu_grant;
    logic                 mul_grant;

    // Both stations see every dispatch and keep only their own unit
    reservation_station #(.UNIT(exec_types_pkg::UNIT_ALU)) alu_rs (
        .clk(clk), .rst(rst),
        .dispatch_valid(dispatch_valid), .dispatch(dispatch), .cdb(cdb),
        .unit_ready(alu_unit_ready), .issue_valid(alu_issue_valid),
        .issue(alu_issue), .full(alu_full)
    );

    reservation_station #(.UNIT(exec_types_pkg::UNIT_MUL)) mul_rs (
        .clk(clk), .rst(rst),
        .dispatch_valid(dispatch_valid), .dispatch(dispatch), .cdb(cdb),
        .unit_ready(mul_unit_ready), .issue_valid(mul_issue_valid),
        .issue(mul_issue), .full(mul_full)
    );

    alu_unit u_alu (
        .clk(clk), .rst(rst),
        .issue_valid(alu_issue_valid), .issue(alu_issue), .grant(alu_grant),
        .unit_ready(alu_unit_ready), .result_valid(alu_res_valid), .result(alu_res)
    );

    mul_unit u_mul (
        .clk(clk), .rst(rst),
        .issue_valid(mul_issue_valid), .issue(mul_issue), .grant(mul_grant),
        .unit_ready(mul_unit_ready), .result_valid(mul_res_valid), .result(mul_res)
    );

    cdb_arbiter u_arb (
        .clk(clk), .rst(rst),
        .alu_valid(alu_res_valid), .alu_result(alu_res),
        .mul_valid(mul_res_valid), .mul_result(mul_res),
        .alu_grant(alu_grant), .mul_grant(mul_grant), .cdb(cdb)
    );

endmodule

`default_nettype wire

//--- verif/exec_core_props.sv
`default_nettype none

`include "exec_config.svh"

module exec_core_props (
    input logic                      clk,
    input logic                      rst,
    input logic                      req_hi,
    input logic                      req_lo,
    input logic                      grant_hi,
    input logic                      grant_lo,
    input logic                      accept,
    input logic                      issue_valid,
    input logic [`EXEC_RS_DEPTH-1:0] slots
);

    // CDB carries one result per cycle
    one_grant: assert property (@(posedge clk) disable iff (rst) !(grant_hi && grant_lo))
        else $error("arbiter granted both units in the same cycle");

    grant_hi_valid: assert property (@(posedge clk) disable iff (rst) grant_hi |-> req_hi)
        else $error("arbiter granted the multiplier without a valid result");

    grant_lo_valid: assert property (@(posedge clk) disable iff (rst) grant_lo |-> req_lo)
        else $error("arbiter granted the ALU without a valid result");

    // A full station has no empty slot, so every accept must add one entry
    no_accept_full: assert property (@(posedge clk) disable iff (rst)
        accept && !issue_valid |=> $countones(slots) == $past($countones(slots)) + 1)
        else $error("station accepted an instruction while full");

endmodule

bind cdb_arbiter exec_core_props arb_props (
    .clk(clk), .rst(rst),
    .req_hi(mul_valid), .req_lo(alu_valid),
    .grant_hi(mul_grant), .grant_lo(alu_grant),
    .accept(1'b0), .issue_valid(1'b0), .slots('0)
);

bind reservation_station exec_core_props rs_props (
    .clk(clk), .rst(rst),
    .req_hi(1'b0), .req_lo(1'b0), .grant_hi(1'b0), .grant_lo(1'b0),
    .accept(accept), .issue_valid(issue_valid), .slots(ent_valid)
);

`default_nettype wire

//--- verif/exec_core_tb.sv
`default_nettype none

`include "exec_config.svh"

module exec_core_tb;

    localparam int MAX_RECS = 64;
    localparam int REC_W    = 8;
    localparam int TIMEOUT  = 200;
    localparam int NTAGS    = 1 << `EXEC_TAG_W;

    // Record kinds
    localparam logic [31:0] K_END   = 32'h0;
    localparam logic [31:0] K_INSTR = 32'h1;
    localparam logic [31:0] K_FULL  = 32'h2;
    localparam logic [31:0] K_DRAIN = 32'h3;

    logic                      clk;
    logic                      rst;
    logic                      dispatch_valid;
    exec_types_pkg::dispatch_t dispatch;
    logic                      alu_full;
    logic                      mul_full;
    exec_bus_pkg::cdb_t        cdb;

    logic [31:0]      stim [MAX_RECS*REC_W];
    logic [31:0]      expect_val [NTAGS];
    logic [NTAGS-1:0] known;
    logic [NTAGS-1:0] sent = '0;
    logic [NTAGS-1:0] seen = '0;
    int               sent_count = 0;
    int               seen_count = 0;
    logic [31:0]      result_sum = '0;
    logic             alu_full_s = 1'b0;
    logic             mul_full_s = 1'b0;
    int               nrecs;

    exec_core dut (
        .clk(clk), .rst(rst),
        .dispatch_valid(dispatch_valid), .dispatch(dispatch),
        .alu_full(alu_full), .mul_full(mul_full), .cdb(cdb)
    );

    always #2 clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            stop_run($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
        end
    endtask

    function automatic logic [31:0] rec_field(input int r, input int f);
        return stim[r*REC_W+f];
    endfunction

    function automatic int rec_tag(input int r, input int f);
        logic [31:0] w;
        w = stim[r*REC_W+f];
        return int'(w[`EXEC_TAG_W-1:0]);
    endfunction

    // Reference ALU from the RV32I rules
    function automatic logic [31:0] alu_ref(input logic [2:0] op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (exec_types_pkg::alu_op_e'(op))
            exec_types_pkg::ALU_ADD: return a + b;
            exec_types_pkg::ALU_SUB: return a - b;
            exec_types_pkg::ALU_AND: return a & b;
            exec_types_pkg::ALU_OR:  return a | b;
            exec_types_pkg::ALU_XOR: return a ^ b;
            exec_types_pkg::ALU_SLL: return a << b[4:0];
            exec_types_pkg::ALU_SRL: return a >> b[4:0];
            default:                 return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] mul_ref(input logic [2:0] op, input logic [31:0] a,
                                            input logic [31:0] b);
        logic signed [63:0] sp;
        logic [63:0]        up;
        sp = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        up = {32'b0, a} * {32'b0, b};
        case (exec_types_pkg::mul_op_e'(op[1:0]))
            exec_types_pkg::MUL_MUL:   return up[31:0];
            exec_types_pkg::MUL_MULH:  return sp[63:32];
            exec_types_pkg::MUL_MULHU: return up[63:32];
            default:                   return 'x;
        endcase
    endfunction

    // Operands whose producer was already broadcast are handed over as values
    function automatic exec_types_pkg::operand_t make_operand(input int r, input int f);
        exec_types_pkg::operand_t o;
        int                       t;
        o = '0;
        t = rec_tag(r, f + 1);
        if (rec_field(r, f) == 32'h0) begin
            o.ready      = 1'b1;
            o.word.value = rec_field(r, f + 1);
        end else if (seen[t]) begin
            o.ready      = 1'b1;
            o.word.value = expect_val[t];
        end else begin
            o.word.src.tag = t[`EXEC_TAG_W-1:0];
        end
        return o;
    endfunction

    function automatic exec_types_pkg::dispatch_t make_dispatch(input int r);
        exec_types_pkg::dispatch_t d;
        d.unit = (rec_field(r, 1) == 32'h1) ? exec_types_pkg::UNIT_MUL : exec_types_pkg::UNIT_ALU;
        d.op   = 3'(rec_field(r, 2));
        d.dest = `EXEC_TAG_W'(rec_tag(r, 3));
        d.src1 = make_operand(r, 4);
        d.src2 = make_operand(r, 6);
        return d;
    endfunction

    // Records may use tags produced later in the file
    task automatic build_model();
        logic [31:0] a;
        logic [31:0] b;
        int          d;
        known = '0;
        for (int pass = 0; pass < nrecs; pass++) begin
            for (int r = 0; r < nrecs; r++) begin
                d = rec_tag(r, 3);
                if (rec_field(r, 0) == K_INSTR && !known[d]
                        && (rec_field(r, 4) == 32'h0 || known[rec_tag(r, 5)])
                        && (rec_field(r, 6) == 32'h0 || known[rec_tag(r, 7)])) begin
                    a = (rec_field(r, 4) == 32'h0) ? rec_field(r, 5) : expect_val[rec_tag(r, 5)];
                    b = (rec_field(r, 6) == 32'h0) ? rec_field(r, 7) : expect_val[rec_tag(r, 7)];
                    if (rec_field(r, 1) == 32'h1) begin
                        expect_val[d] = mul_ref(3'(rec_field(r, 2)), a, b);
                    end else begin
                        expect_val[d] = alu_ref(3'(rec_field(r, 2)), a, b);
                    end
                    known[d] = 1'b1;
                end
            end
        end
        for (int r = 0; r < nrecs; r++) begin
            if (rec_field(r, 0) == K_INSTR && !known[rec_tag(r, 3)]) begin
                stop_run($sformatf("stimulus tag %0d depends on a tag nothing produces",
                                   rec_tag(r, 3)));
            end
        end
    endtask

    // Entered at a rising edge, returns at the edge that accepts the record
    task automatic send_instr(input int r);
        int   cycles;
        logic busy;
        cycles = 0;
        dispatch_valid <= 1'b1;
        dispatch       <= make_dispatch(r);
        @(posedge clk);
        busy = (rec_field(r, 1) == 32'h1) ? mul_full_s : alu_full_s;
        while (busy) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_run($sformatf("timeout waiting to dispatch tag %0d", rec_tag(r, 3)));
            end
            dispatch <= make_dispatch(r);
            @(posedge clk);
            busy = (rec_field(r, 1) == 32'h1) ? mul_full_s : alu_full_s;
        end
        sent[rec_tag(r, 3)] = 1'b1;
        sent_count++;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (seen_count != sent_count) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_run("timeout waiting for dispatched results to reach the CDB");
            end
        end
    endtask

    task automatic wait_alu_full();
        int cycles;
        cycles = 0;
        while (!alu_full_s) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_run("timeout waiting for the ALU station to report full");
            end
        end
    endtask

    // Sample outputs mid-cycle and score every broadcast
    always @(negedge clk) begin : cdb_monitor
        int t;
        alu_full_s = alu_full;
        mul_full_s = mul_full;
        if (!rst && cdb.valid) begin
            t = int'(cdb.tag);
            if (!sent[t]) begin
                stop_run($sformatf("CDB broadcast tag %0d that was never dispatched", t));
            end
            if (seen[t]) begin
                stop_run($sformatf("CDB broadcast tag %0d a second time", t));
            end
            check_value($sformatf("cdb tag %0d", t), expect_val[t], cdb.value);
            seen[t] = 1'b1;
            seen_count++;
            result_sum = result_sum + cdb.value;
        end
    end

    initial begin : main
        logic [31:0] kind;
        clk            = 1'b0;
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        $readmemh("verif/exec_stim.txt", stim);
        nrecs = 0;
        while (nrecs < MAX_RECS && rec_field(nrecs, 0) !== K_END) begin
            nrecs++;
        end
        if (nrecs == MAX_RECS) begin
            stop_run("stimulus file missing or without an end record");
        end
        build_model();

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("reset cdb valid", 32'h0, {31'b0, cdb.valid});
        check_value("reset alu_full", 32'h0, {31'b0, alu_full});
        check_value("reset mul_full", 32'h0, {31'b0, mul_full});

        @(posedge clk);
        for (int r = 0; r < nrecs; r++) begin
            kind = rec_field(r, 0);
            if (kind == K_INSTR) begin
                send_instr(r);
            end else if (kind == K_FULL) begin
                dispatch_valid <= 1'b0;
                wait_alu_full();
            end else if (kind == K_DRAIN) begin
                dispatch_valid <= 1'b0;
                wait_drain();
            end
        end
        dispatch_valid <= 1'b0;
        wait_drain();
        check_value("checksum", rec_field(nrecs, 5), result_sum);

        if (seen == sent) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            stop_run("some dispatched tags never appeared on the CDB");
        end
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+source
source/exec_types_pkg.sv
source/exec_bus_pkg.sv
source/reservation_station.sv
source/alu_unit.sv
source/mul_unit.sv
source/cdb_arbiter.sv
source/exec_core.sv
verif/exec_core_props.sv
verif/exec_core_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module exec_core_tb -f flist.f -o exec_core_sim \
    && ./obj_dir/exec_core_sim 2>&1 | tee sim.log
grep -q "=== PASS ===" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- verif/exec_stim.txt
// kind unit op dest s1_tag s1 s2_tag s2 ; kind 1 instr, 2 wait alu full, 3 drain, 0 end
// unit 0 alu, 1 mul ; s_tag 1 means the next column is a producer tag ; end s1 is checksum
1 0 0 01 0 00001234 0 00000f00
1 0 1 02 0 00000010 0 00000020
1 0 2 03 0 f0f0f0f0 0 0ff00ff0
1 0 3 04 0 12340000 0 00005678
1 0 4 05 0 aaaa5555 0 ffff0000
1 0 5 06 0 00000003 0 00000024
1 0 6 07 0 80000000 0 0000001f
1 0 7 08 0 ffffffff 0 00000001
1 1 0 09 0 00001000 0 00000300
1 1 1 0a 0 fffffffe 0 00000003
1 1 2 0b 0 fffffffe 0 00000003
1 0 0 0c 1 09 0 00000005
1 1 0 0d 1 0c 0 00000002
1 0 4 0e 1 0d 1 04
3 0 0 00 0 0 0 0
// Eight ALU ops waiting on a multiply that is not dispatched yet
1 0 0 10 1 1f 0 00000001
1 0 1 11 1 1f 0 00000002
1 0 2 12 1 1f 0 0000000f
1 0 3 13 1 1f 0 00000100
1 0 4 14 1 1f 0 000000ff
1 0 5 15 1 1f 0 00000004
1 0 6 16 1 1f 0 00000001
1 0 7 17 1 1f 0 00000030
2 0 0 00 0 0 0 0
1 1 0 1f 0 00000007 0 00000006
3 0 0 00 0 0 0 0
1 1 2 20 0 80000000 0 00000004
1 0 0 21 0 00000100 0 00000001
1 0 3 22 0 00000f00 0 000000f0
1 1 1 23 0 80000000 0 80000000
1 0 1 24 0 00000050 0 00000008
1 1 0 25 0 00000011 0 00000011
1 0 2 26 1 23 0 f0000000
0 0 0 00 0 fb8e3c2d 0 0
